//--- design/tlb_pkg.sv
package tlb_pkg;

    localparam int tlb_entries   = 16;
    localparam int tlb_index_w   = 4;
    localparam int page_offset_w = 12;                 // 4 KB pages
    localparam int vpn_w         = 32 - page_offset_w;

    // one joint TLB entry of 50 bits
    typedef struct packed {
        logic [vpn_w-1:0] vpn;
        logic [3:0]       asid;
        logic [19:0]      pfn;
        logic [2:0]       c;     // cache attribute passed through
        logic             d;     // dirty bit passed through
        logic             v;
        logic             g;
    } tlb_entry_t;

    // outcome of one sequential search
    typedef struct packed {
        logic                   found;
        logic [tlb_index_w-1:0] index;
        tlb_entry_t             entry;
    } tlb_result_t;

    // what the fetch side sees
    typedef struct packed {
        logic [31:0] paddr;
        logic        refill;
        logic        invalid;
    } xlate_t;

    // segments 8 to B bypass the TLB
    function automatic logic seg_unmapped(input logic [3:0] seg);
        return seg[3:2] == 2'b10;
    endfunction

endpackage

//--- design/itlb_ctrl.sv
`timescale 1ns/100ps

module itlb_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic buf_hit,
    input  logic search_done,
    input  logic flush,
    input  logic tlb_we,
    output logic search_start,
    output logic buf_wr,
    output logic searching
);

    typedef enum logic [1:0] {
        st_idle,
        st_search,
        st_fill
    } state_t;

    state_t state, state_nxt;
    logic   abort;

    assign abort = flush | tlb_we;   // the buffer is cleared as well

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (!buf_hit) begin
                    state_nxt = st_search;
                end
            end
            st_search: begin
                if (search_done) begin
                    state_nxt = st_fill;
                end
            end
            st_fill: state_nxt = st_idle;   // one write cycle
            default: state_nxt = st_idle;
        endcase
        if (abort) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            search_start <= 1'b0;
        end else begin
            state        <= state_nxt;
            // high during the first search cycle
            search_start <= (state == st_idle) && (state_nxt == st_search);
        end
    end

    assign searching = (state == st_search);
    assign buf_wr    = (state == st_fill);

endmodule

//--- design/tlb_search_counter.sv
`timescale 1ns/100ps

module tlb_search_counter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              search_start,
    input  logic                              searching,
    input  logic                              entry_match,
    input  tlb_pkg::tlb_entry_t               entry,
    output logic [tlb_pkg::tlb_index_w-1:0]   search_index,
    output logic                              search_done,
    output tlb_pkg::tlb_result_t              result
);

    logic [tlb_pkg::tlb_index_w-1:0] idx_q;
    logic                            last;
    logic                            active;
    logic                            finish;

    // index 0 is checked in the start cycle itself
    assign search_index = search_start ? '0 : idx_q;

    assign last   = (search_index == tlb_pkg::tlb_entries - 1);
    assign active = searching && (search_start || !search_done);
    assign finish = active && (entry_match || last);

    always_ff @(posedge clk) begin
        if (reset) begin
            idx_q       <= '0;
            search_done <= 1'b0;
        end else begin
            search_done <= finish;   // one-cycle pulse
            if (active && !finish) begin
                idx_q <= search_index + 1'b1;
            end
        end
    end

    // result of the finished search
    always_ff @(posedge clk) begin
        if (finish) begin
            result.found <= entry_match;
            result.index <= search_index;
            result.entry <= entry_match ? entry : '0;   // empty on a full miss
        end
    end

endmodule

//--- design/tlb_array.sv
`timescale 1ns/100ps

module tlb_array (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              tlb_we,
    input  logic [tlb_pkg::tlb_index_w-1:0]   tlb_windex,
    input  tlb_pkg::tlb_entry_t               tlb_wentry,
    input  logic [tlb_pkg::tlb_index_w-1:0]   search_index,
    input  logic [tlb_pkg::vpn_w-1:0]         vpn,
    input  logic [3:0]                        cur_asid,
    output tlb_pkg::tlb_entry_t               entry,
    output logic                              entry_match
);

    tlb_pkg::tlb_entry_t mem [tlb_pkg::tlb_entries];

    logic vpn_eq;
    logic asid_ok;

    // software write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                mem[i] <= '0;
            end
        end else if (tlb_we) begin
            mem[tlb_windex] <= tlb_wentry;
        end
    end

    // indexed compare port
    assign entry = mem[search_index];

    assign vpn_eq      = (entry.vpn == vpn);
    assign asid_ok     = (entry.asid == cur_asid) || entry.g;
    assign entry_match = vpn_eq && asid_ok;   // v is not part of the match

endmodule

//--- design/itlb_buffer.sv
`timescale 1ns/100ps

module itlb_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 buf_wr,
    input  tlb_pkg::tlb_result_t result,
    input  logic [31:0]          vaddr,
    input  logic [3:0]           cur_asid,
    output logic                 buf_hit,
    output tlb_pkg::tlb_result_t buf_result
);

    logic                      valid;
    logic [tlb_pkg::vpn_w-1:0] tag_vpn;
    logic [3:0]                tag_asid;
    logic                      tag_match;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            valid <= 1'b0;
        end else if (buf_wr) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr) begin
            buf_result <= result;
            tag_vpn    <= vaddr[31:tlb_pkg::page_offset_w];   // virtual page tag
            tag_asid   <= cur_asid;
        end
    end

    assign tag_match = (tag_vpn == vaddr[31:tlb_pkg::page_offset_w])
                    && ((tag_asid == cur_asid) || buf_result.entry.g);

    assign buf_hit = tlb_pkg::seg_unmapped(vaddr[31:28]) || (valid && tag_match);

endmodule

//--- design/itlb_translate.sv
`timescale 1ns/100ps

module itlb_translate (
    input  logic [31:0]          vaddr,
    input  tlb_pkg::tlb_result_t buf_result,
    output tlb_pkg::xlate_t      xlate
);

    logic [3:0] seg;
    logic       mapped;

    assign seg    = vaddr[31:28];
    assign mapped = !tlb_pkg::seg_unmapped(seg);

    always_comb begin
        if (!mapped && seg[1]) begin
            xlate.paddr = {3'b000, vaddr[28:0]};   // segments A, B
        end else if (!mapped) begin
            xlate.paddr = {1'b0, vaddr[30:0]};     // segments 8, 9
        end else begin
            xlate.paddr = {buf_result.entry.pfn, vaddr[tlb_pkg::page_offset_w-1:0]};
        end
    end

    // exceptions only apply to mapped segments
    assign xlate.refill  = mapped && !buf_result.found;
    assign xlate.invalid = mapped && buf_result.found && !buf_result.entry.v;

endmodule

//--- design/itlb_top.sv
`timescale 1ns/100ps

module itlb_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [31:0]                     vaddr,
    input  logic [3:0]                      cur_asid,
    input  logic                            tlb_we,
    input  logic [tlb_pkg::tlb_index_w-1:0] tlb_windex,
    input  tlb_pkg::tlb_entry_t             tlb_wentry,
    input  logic                            flush,
    output tlb_pkg::xlate_t                 xlate,
    output logic                            stall
);

    logic                            buf_hit;
    logic                            buf_clear;
    logic                            search_start;
    logic                            searching;
    logic                            search_done;
    logic                            buf_wr;
    logic                            entry_match;
    logic [tlb_pkg::tlb_index_w-1:0] search_index;
    tlb_pkg::tlb_entry_t             entry;
    tlb_pkg::tlb_result_t            result;
    tlb_pkg::tlb_result_t            buf_result;

    assign buf_clear = flush | tlb_we;   // any TLB change invalidates the buffer
    assign stall     = ~buf_hit;

    itlb_ctrl i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .buf_hit      (buf_hit),
        .search_done  (search_done),
        .flush        (flush),
        .tlb_we       (tlb_we),
        .search_start (search_start),
        .buf_wr       (buf_wr),
        .searching    (searching)
    );

    tlb_search_counter i_counter (
        .clk          (clk),
        .reset        (reset),
        .search_start (search_start),
        .searching    (searching),
        .entry_match  (entry_match),
        .entry        (entry),
        .search_index (search_index),
        .search_done  (search_done),
        .result       (result)
    );

    tlb_array i_tlb (
        .clk          (clk),
        .reset        (reset),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wentry   (tlb_wentry),
        .search_index (search_index),
        .vpn          (vaddr[31:tlb_pkg::page_offset_w]),
        .cur_asid     (cur_asid),
        .entry        (entry),
        .entry_match  (entry_match)
    );

    itlb_buffer i_buffer (
        .clk        (clk),
        .reset      (reset),
        .clear      (buf_clear),
        .buf_wr     (buf_wr),
        .result     (result),
        .vaddr      (vaddr),
        .cur_asid   (cur_asid),
        .buf_hit    (buf_hit),
        .buf_result (buf_result)
    );

    itlb_translate i_translate (
        .vaddr      (vaddr),
        .buf_result (buf_result),
        .xlate      (xlate)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 20;   // 40 ns clock
    localparam int reset_cycles = 2;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- test/itlb_props.sv
`timescale 1ns/100ps

module itlb_props (
    input logic clk,
    input logic reset,
    input logic search_start,
    input logic buf_wr,
    input logic searching
);

    int assert_failures = 0;   // count of failed assertions

    a_fill_one_cycle: assert property (@(posedge clk) disable iff (reset)
        buf_wr |=> !buf_wr)
        else begin
            $error("buf_wr stayed high for more than one cycle");
            assert_failures++;
        end

    a_start_fill_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(search_start && buf_wr))
        else begin
            $error("search_start and buf_wr high together");
            assert_failures++;
        end

    // controller comes out of reset quiet
    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> !search_start && !buf_wr && !searching)
        else begin
            $error("control output high in the cycle after reset");
            assert_failures++;
        end

endmodule

bind itlb_ctrl itlb_props i_props (
    .clk          (clk),
    .reset        (reset),
    .search_start (search_start),
    .buf_wr       (buf_wr),
    .searching    (searching)
);

//--- test/itlb_tb.sv
`timescale 1ns/100ps

module itlb_tb;

    localparam int n_random        = 200;
    localparam int n_lookups       = n_random + 16 + 40;
    localparam int watchdog_cycles = n_lookups * 20 + 1000;   // 20 per lookup plus margin
    localparam logic [19:0] rand_vpn_base = 20'h3C000;

    logic                            clk;
    logic                            reset;
    logic [31:0]                     vaddr;
    logic [3:0]                      cur_asid;
    logic                            tlb_we;
    logic [tlb_pkg::tlb_index_w-1:0] tlb_windex;
    tlb_pkg::tlb_entry_t             tlb_wentry;
    logic                            flush;
    tlb_pkg::xlate_t                 xlate;
    logic                            stall;

    tlb_pkg::tlb_entry_t ref_tlb [tlb_pkg::tlb_entries];
    logic [31:0]         lcg_state = 32'd56871;
    string               test_name;
    int                  checks_done = 0;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    itlb_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .vaddr      (vaddr),
        .cur_asid   (cur_asid),
        .tlb_we     (tlb_we),
        .tlb_windex (tlb_windex),
        .tlb_wentry (tlb_wentry),
        .flush      (flush),
        .xlate      (xlate),
        .stall      (stall)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic tlb_pkg::tlb_entry_t make_entry(input logic [19:0] vpn,
            input logic [3:0] asid, input logic [19:0] pfn, input logic v, input logic g);
        tlb_pkg::tlb_entry_t e;
        e      = '0;
        e.vpn  = vpn;
        e.asid = asid;
        e.pfn  = pfn;
        e.v    = v;
        e.g    = g;
        return e;
    endfunction

    // one vpn per index keeps the lowest match unique
    function automatic tlb_pkg::tlb_entry_t random_entry(input logic [3:0] idx);
        tlb_pkg::tlb_entry_t e;
        logic [31:0]         r;
        r      = next_rand();
        e.vpn  = rand_vpn_base + idx;
        e.asid = {2'b00, r[31:30]};
        e.pfn  = r[27:8];
        e.c    = r[7:5];
        e.d    = r[4];
        e.v    = (r[3:1] != 3'b000);
        e.g    = (r[29:28] == 2'b00);
        return e;
    endfunction

    // expected translation from the segment rules and the lowest matching entry
    function automatic tlb_pkg::xlate_t ref_xlate(input logic [31:0] va, input logic [3:0] asid);
        tlb_pkg::xlate_t x;
        logic [3:0]      seg;
        logic            hit;
        x   = '0;
        seg = va[31:28];
        hit = 1'b0;
        if (tlb_pkg::seg_unmapped(seg)) begin
            if (seg >= 4'hA) begin
                x.paddr = {3'b000, va[28:0]};
            end else begin
                x.paddr = {1'b0, va[30:0]};
            end
        end else begin
            for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                if (!hit && ref_tlb[i].vpn == va[31:12]
                        && (ref_tlb[i].asid == asid || ref_tlb[i].g)) begin
                    hit       = 1'b1;
                    x.paddr   = {ref_tlb[i].pfn, va[11:0]};
                    x.invalid = !ref_tlb[i].v;
                end
            end
            x.refill = !hit;
        end
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_ready(output int waited);
        waited = 0;
        @(negedge clk);
        while (stall) begin
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic fetch(input logic [31:0] va, input logic [3:0] asid, output int waited);
        @(posedge clk);
        vaddr    <= va;
        cur_asid <= asid;
        wait_ready(waited);
    endtask

    // paddr means nothing on a refill
    task automatic lookup(input logic [31:0] va, input logic [3:0] asid,
            input logic [31:0] paddr, input logic refill, input logic invalid,
            output int waited);
        fetch(va, asid, waited);
        if (refill) begin
            check_value(test_name, {refill, invalid}, {xlate.refill, xlate.invalid});
        end else begin
            check_value(test_name, {paddr, refill, invalid}, xlate);
        end
    endtask

    task automatic write_entry(input logic [3:0] idx, input tlb_pkg::tlb_entry_t e,
            output int waited);
        @(posedge clk);
        tlb_we     <= 1'b1;
        tlb_windex <= idx;
        tlb_wentry <= e;
        @(posedge clk);
        tlb_we     <= 1'b0;
        wait_ready(waited);   // fetch holds vaddr until the refill search is done
    endtask

    task automatic flush_buffer(output int waited);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_ready(waited);
    endtask

    // mirrors the software writes the DUT sees
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                ref_tlb[i] <= '0;
            end
        end else if (tlb_we) begin
            ref_tlb[tlb_windex] <= tlb_wentry;
        end
    end

    always @(negedge clk) begin : compare
        tlb_pkg::xlate_t exp_x;
        tlb_pkg::xlate_t act_x;
        if (i_dut.i_ctrl.i_props.assert_failures != 0) begin
            $display("an assertion on the control FSM failed");
            $display("test failed");
            $fatal(1, "assertion failure");
        end else if (!reset && !stall) begin
            exp_x = ref_xlate(vaddr, cur_asid);
            act_x = xlate;
            if (exp_x.refill) begin
                exp_x.paddr = '0;
                act_x.paddr = '0;
            end
            check_value({test_name, " vs reference"}, exp_x, act_x);
            checks_done++;
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: stall never fell within %0d cycles", watchdog_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int          waited;
        logic [3:0]  idx;
        logic [31:0] r;
        logic [31:0] r2;
        vaddr      = 32'h8000_0000;
        cur_asid   = '0;
        tlb_we     = 1'b0;
        tlb_windex = '0;
        tlb_wentry = '0;
        flush      = 1'b0;
        test_name  = "reset";
        wait (reset == 1'b0);

        test_name = "unmapped";
        lookup(32'h8012_3456, 4'h0, 32'h0012_3456, 1'b0, 1'b0, waited);
        check_value("unmapped stall 8", 0, waited);
        lookup(32'h9ABC_DEF0, 4'h0, 32'h1ABC_DEF0, 1'b0, 1'b0, waited);
        check_value("unmapped stall 9", 0, waited);
        lookup(32'hA765_4321, 4'h0, 32'h0765_4321, 1'b0, 1'b0, waited);
        check_value("unmapped stall A", 0, waited);
        lookup(32'hBFFF_F004, 4'h0, 32'h1FFF_F004, 1'b0, 1'b0, waited);
        check_value("unmapped stall B", 0, waited);

        test_name = "mapped_hit";
        write_entry(4'd0, make_entry(20'h12340, 4'h1, 20'h0A0A0, 1'b1, 1'b0), waited);
        write_entry(4'd7, make_entry(20'h12347, 4'h1, 20'h77777, 1'b1, 1'b0), waited);
        write_entry(4'd15, make_entry(20'h1234F, 4'h1, 20'hFFF0F, 1'b1, 1'b0), waited);
        lookup(32'h1234_0ABC, 4'h1, 32'h0A0A_0ABC, 1'b0, 1'b0, waited);
        lookup(32'h1234_7123, 4'h1, 32'h7777_7123, 1'b0, 1'b0, waited);
        lookup(32'h1234_F456, 4'h1, 32'hFFF0_F456, 1'b0, 1'b0, waited);
        check_value("mapped_hit index 15 latency", 1, waited > 15 && waited <= 20);

        test_name = "refill_asid";
        lookup(32'h5555_5000, 4'h1, 32'h0, 1'b1, 1'b0, waited);
        write_entry(4'd2, make_entry(20'h60002, 4'h3, 20'h22222, 1'b1, 1'b0), waited);
        write_entry(4'd9, make_entry(20'h60009, 4'h3, 20'h99999, 1'b1, 1'b1), waited);
        lookup(32'h6000_2010, 4'h3, 32'h2222_2010, 1'b0, 1'b0, waited);
        lookup(32'h6000_2010, 4'h4, 32'h0, 1'b1, 1'b0, waited);
        lookup(32'h6000_9020, 4'h4, 32'h9999_9020, 1'b0, 1'b0, waited);   // global

        test_name = "invalid";
        write_entry(4'd4, make_entry(20'h70004, 4'h2, 20'h44444, 1'b0, 1'b0), waited);
        lookup(32'h7000_4ABC, 4'h2, 32'h4444_4ABC, 1'b0, 1'b1, waited);

        test_name = "same_page";
        lookup(32'h1234_7000, 4'h1, 32'h7777_7000, 1'b0, 1'b0, waited);
        lookup(32'h1234_7004, 4'h1, 32'h7777_7004, 1'b0, 1'b0, waited);
        check_value("same_page stall", 0, waited);
        lookup(32'h1234_7FFC, 4'h1, 32'h7777_7FFC, 1'b0, 1'b0, waited);
        check_value("same_page stall", 0, waited);
        write_entry(4'd7, make_entry(20'h12347, 4'h1, 20'h7ABCD, 1'b1, 1'b0), waited);
        check_value("same_page stall after write", 1, waited > 0);
        lookup(32'h1234_7008, 4'h1, 32'h7ABC_D008, 1'b0, 1'b0, waited);
        flush_buffer(waited);
        check_value("same_page stall after flush", 1, waited > 0);
        lookup(32'h1234_700C, 4'h1, 32'h7ABC_D00C, 1'b0, 1'b0, waited);

        test_name = "random";
        for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
            idx = i;
            write_entry(idx, random_entry(idx), waited);
        end
        for (int n = 0; n < n_random; n++) begin
            r  = next_rand();
            r2 = next_rand();
            case (r[31:28])
                4'h0, 4'h1, 4'h2: begin
                    idx = r[15:12];
                    write_entry(idx, random_entry(idx), waited);
                end
                4'h3: flush_buffer(waited);
                4'h4, 4'h5: fetch({2'b10, r2[29:0]}, {2'b00, r[21:20]}, waited);
                default: begin
                    fetch({rand_vpn_base + 20'(r2 % 20), r2[31:20]}, {2'b00, r[21:20]},
                          waited);
                end
            endcase
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        if (checks_done > 0 && i_dut.i_ctrl.i_props.assert_failures == 0) begin
            $display("test passed");
        end else begin
            $display("no translation was compared or an assertion failed");
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- itlb_top.f
design/tlb_pkg.sv
design/itlb_ctrl.sv
design/tlb_search_counter.sv
design/tlb_array.sv
design/itlb_buffer.sv
design/itlb_translate.sv
design/itlb_top.sv
test/tb_clock.sv
test/itlb_props.sv
test/itlb_tb.sv

//--- Bender.yml
package:
  name: itlb

sources:
  - design/tlb_pkg.sv
  - design/itlb_ctrl.sv
  - design/tlb_search_counter.sv
  - design/tlb_array.sv
  - design/itlb_buffer.sv
  - design/itlb_translate.sv
  - design/itlb_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/itlb_props.sv
      - test/itlb_tb.sv
